// ==== src/saturn_pkg.sv ====
// Saturn front end shared definitions
// Address and nibble types, ALU operand and opcode encodings,
// instruction classes and the bus cycle phase count

`default_nettype none

package saturn_pkg;

    // Four clock phases make one nibble bus cycle
    localparam int PHASE_COUNT = 4;

    // 20-bit nibble address space
    typedef logic [19:0] addr_t;

    // One data nibble
    typedef logic [3:0] nibble_t;

    // GOTO displacement, three nibbles, two's complement
    typedef logic signed [11:0] offset_t;

    // ALU register operands
    typedef enum logic [4:0] {
        REG_P    = 5'd4,
        REG_IMM  = 5'd16,
        REG_NONE = 5'd31
    } alu_reg_t;

    // ALU operations
    typedef enum logic [4:0] {
        OP_NOP  = 5'd0,
        OP_COPY = 5'd1
    } alu_op_t;

    // Instruction classes seen by the execute stage
    typedef enum logic [3:0] {
        TYPE_ALU  = 4'd0,
        TYPE_JUMP = 4'd1,
        TYPE_NOP  = 4'd2,
        // Nothing decoded yet
        TYPE_NONE = 4'd15
    } instr_type_t;

endpackage

`default_nettype wire

// ==== src/saturn_phase_gen.sv ====
// Bus cycle phase sequencer
// Rotates a one-hot phase vector through the four phases of a nibble
// cycle, holding it whenever the clock enable is low or the bus is busy

`default_nettype none

module saturn_phase_gen import saturn_pkg::*; (
    input  wire                    i_clk,
    input  wire                    i_reset,
    input  wire                    i_clk_en,
    input  wire                    i_bus_busy,
    output logic [PHASE_COUNT-1:0] o_phases
);

    logic active;

    // Pipeline moves only on enabled, non-busy cycles
    assign active = i_clk_en && !i_bus_busy;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            // Start in phase 0
            o_phases <= {{(PHASE_COUNT - 1){1'b0}}, 1'b1};
        end else if (active) begin
            // Rotate left, phase 3 wraps back to phase 0
            o_phases <= {o_phases[PHASE_COUNT-2:0], o_phases[PHASE_COUNT-1]};
        end
    end

    // Exactly one phase is live at any time
    a_phases_onehot: assert property (
        @(posedge i_clk) disable iff (i_reset)
        $onehot(o_phases)
    ) else $error("phase vector not one-hot: %b", o_phases);

endmodule

`default_nettype wire

// ==== src/saturn_fetch.sv ====
// Fetch stage
// Holds the program counter, which addresses the external nibble memory.
// At the end of every bus cycle it steps to the next nibble, or takes
// the jump target when the execute stage resolves a GOTO

`default_nettype none

module saturn_fetch import saturn_pkg::*; #(
    parameter addr_t RESET_PC = '0
) (
    input  wire                    i_clk,
    input  wire                    i_reset,
    input  wire                    i_clk_en,
    input  wire                    i_bus_busy,
    input  wire [PHASE_COUNT-1:0]  i_phases,
    input  wire                    i_jump,
    input  addr_t                  i_jump_target,
    output addr_t                  o_pc
);

    logic  active;
    addr_t pc_next;

    assign active = i_clk_en && !i_bus_busy;

    // Next address
    // A jump strobe only ever shows up in phase 3, together with
    // the decoded pulse of the last GOTO offset nibble
    always_comb begin
        if (i_jump) begin
            pc_next = i_jump_target;
        end else begin
            pc_next = o_pc + addr_t'(1);
        end
    end

    // PC register
    // Memory returns the nibble combinationally, so the address must
    // stay put for the whole bus cycle and only move at its last edge
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_pc <= RESET_PC;
        end else if (active && i_phases[3]) begin
            o_pc <= pc_next;
        end
    end

    // Address stays frozen across a busy bus
    a_pc_stable_busy: assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_bus_busy |=> $stable(o_pc)
    ) else $error("o_pc moved while bus busy: %h", o_pc);

endmodule

`default_nettype wire

// ==== src/saturn_inst_decoder.sv ====
// Instruction decoder
// Consumes one nibble per bus cycle and finds instruction boundaries.
// Handles P= n (2n), GOTO (6xyz) and treats any other nibble as a NOP.
// Pulses decoded, execute and offset strobe during phase 3

`default_nettype none

module saturn_inst_decoder import saturn_pkg::*; (
    input  wire                    i_clk,
    input  wire                    i_reset,
    input  wire                    i_clk_en,
    input  wire                    i_bus_busy,
    input  wire [PHASE_COUNT-1:0]  i_phases,
    input  nibble_t                i_nibble,
    input  addr_t                  i_current_pc,
    output addr_t                  o_instr_pc,
    output alu_reg_t               o_alu_reg_dest,
    output alu_reg_t               o_alu_reg_src_1,
    output alu_reg_t               o_alu_reg_src_2,
    output nibble_t                o_alu_imm_value,
    output alu_op_t                o_alu_opcode,
    output instr_type_t            o_instr_type,
    output logic                   o_offset_strobe,
    output logic                   o_instr_decoded,
    output logic                   o_instr_execute,
    output addr_t                  o_dbg_inst_addr
);

    // First nibble opcodes
    localparam nibble_t NIB_P_EQ = 4'h2;
    localparam nibble_t NIB_GOTO = 4'h6;

    // IDLE means the next nibble starts a new instruction
    typedef enum logic [1:0] {
        IDLE,
        P_IMM,
        JUMP_OFS
    } dec_state_t;

    dec_state_t state;
    logic [1:0] ofs_cnt;
    logic       active;

    assign active = i_clk_en && !i_bus_busy;

    // Instruction address, captured at the first nibble
    always_ff @(posedge i_clk) begin
        if (active && i_phases[1] && (state == IDLE)) begin
            o_instr_pc <= i_current_pc;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state           <= IDLE;
            ofs_cnt         <= '0;
            o_alu_reg_dest  <= REG_NONE;
            o_alu_reg_src_1 <= REG_NONE;
            o_alu_reg_src_2 <= REG_NONE;
            o_alu_imm_value <= '0;
            o_alu_opcode    <= OP_NOP;
            o_instr_type    <= TYPE_NONE;
            o_offset_strobe <= 1'b0;
            o_instr_decoded <= 1'b0;
            o_instr_execute <= 1'b0;
            o_dbg_inst_addr <= '0;
        end else if (active) begin
            // New instruction defaults to NOP so nothing stale executes
            if (i_phases[1] && (state == IDLE)) begin
                o_instr_type <= TYPE_NOP;
            end

            // Nibble is valid on i_nibble by phase 2
            if (i_phases[2]) begin
                case (state)
                    IDLE: begin
                        case (i_nibble)
                            NIB_P_EQ: state <= P_IMM;
                            NIB_GOTO: begin
                                o_instr_type <= TYPE_JUMP;
                                ofs_cnt      <= '0;
                                state        <= JUMP_OFS;
                            end
                            default: begin
                                // Single nibble NOP, done right away
                                o_instr_type    <= TYPE_NOP;
                                o_instr_decoded <= 1'b1;
                                o_dbg_inst_addr <= o_instr_pc;
                            end
                        endcase
                    end
                    P_IMM: begin
                        // P= n, immediate copied into P
                        o_alu_reg_dest  <= REG_P;
                        o_alu_reg_src_1 <= REG_IMM;
                        o_alu_reg_src_2 <= REG_NONE;
                        o_alu_imm_value <= i_nibble;
                        o_alu_opcode    <= OP_COPY;
                        o_instr_type    <= TYPE_ALU;
                        o_instr_decoded <= 1'b1;
                        o_instr_execute <= 1'b1;
                        o_dbg_inst_addr <= o_instr_pc;
                        state           <= IDLE;
                    end
                    JUMP_OFS: begin
                        // One strobe per offset nibble, low nibble first
                        o_offset_strobe <= 1'b1;
                        ofs_cnt         <= ofs_cnt + 2'd1;
                        if (ofs_cnt == 2'd2) begin
                            // Third offset nibble ends the GOTO
                            o_instr_decoded <= 1'b1;
                            o_dbg_inst_addr <= o_instr_pc;
                            state           <= IDLE;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end

            // Pulses live for phase 3 only
            if (i_phases[3]) begin
                o_offset_strobe <= 1'b0;
                o_instr_decoded <= 1'b0;
                o_instr_execute <= 1'b0;
            end
        end
    end

    // Offset nibbles only ever belong to a GOTO
    a_strobe_in_jump: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_offset_strobe |-> (o_instr_type == TYPE_JUMP)
    ) else $error("offset strobe with type %h", o_instr_type);

endmodule

`default_nettype wire

// ==== src/saturn_exec.sv ====
// Execute stage
// Owns register P and the GOTO offset shift register.
// Performs the immediate copy into P, and forms the jump target as
// instruction address + 1 + sign-extended offset

`default_nettype none

module saturn_exec import saturn_pkg::*; (
    input  wire                    i_clk,
    input  wire                    i_reset,
    input  wire                    i_clk_en,
    input  wire                    i_bus_busy,
    input  wire [PHASE_COUNT-1:0]  i_phases,
    input  nibble_t                i_nibble,
    input  addr_t                  i_instr_pc,
    input  alu_reg_t               i_alu_reg_dest,
    input  alu_reg_t               i_alu_reg_src_1,
    input  nibble_t                i_alu_imm_value,
    input  alu_op_t                i_alu_opcode,
    input  instr_type_t            i_instr_type,
    input  wire                    i_offset_strobe,
    input  wire                    i_instr_decoded,
    input  wire                    i_instr_execute,
    output nibble_t                o_reg_p,
    output logic                   o_jump,
    output addr_t                  o_jump_target
);

    logic    active;
    nibble_t nibble_q;
    offset_t offset_sr;
    offset_t offset_next;
    addr_t   offset_ext;

    assign active = i_clk_en && !i_bus_busy;

    // Bus nibble, sampled with the decoder in phase 2
    always_ff @(posedge i_clk) begin
        if (active && i_phases[2]) begin
            nibble_q <= i_nibble;
        end
    end

    // New nibble enters at the top, earlier ones slide down
    assign offset_next = {nibble_q, offset_sr[11:4]};

    always_ff @(posedge i_clk) begin
        if (active && i_phases[3] && i_offset_strobe) begin
            offset_sr <= offset_next;
        end
    end

    // Last offset nibble arrives with decoded, so use the shifted value
    assign offset_ext = {{($bits(addr_t) - $bits(offset_t)){offset_next[11]}}, offset_next};

    // Offset counts from the nibble just after the 6
    assign o_jump_target = i_instr_pc + addr_t'(1) + offset_ext;

    // Decoded is phase 3 only, so the jump lasts one phase
    assign o_jump = i_instr_decoded && (i_instr_type == TYPE_JUMP);

    // Register P
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_reg_p <= '0;
        end else if (active && i_phases[3] && i_instr_execute) begin
            if ((i_instr_type == TYPE_ALU) && (i_alu_opcode == OP_COPY) &&
                (i_alu_reg_dest == REG_P) && (i_alu_reg_src_1 == REG_IMM)) begin
                o_reg_p <= i_alu_imm_value;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/saturn_core.sv ====
// Saturn front end top level
// Phase generator, fetch, decoder and execute stages.
// Nibble memory sits outside and answers o_pc on i_nibble

`default_nettype none

module saturn_core import saturn_pkg::*; #(
    parameter addr_t RESET_PC = '0
) (
    input  wire          i_clk,
    input  wire          i_reset,
    input  wire          i_clk_en,
    input  wire          i_bus_busy,
    input  nibble_t      i_nibble,
    output addr_t        o_pc,
    output nibble_t      o_reg_p,
    output instr_type_t  o_instr_type,
    output logic         o_instr_decoded,
    output addr_t        o_dbg_inst_addr
);

    logic [PHASE_COUNT-1:0] phases;

    // Decoder to execute
    addr_t    instr_pc;
    alu_reg_t alu_reg_dest;
    alu_reg_t alu_reg_src_1;
    nibble_t  alu_imm_value;
    alu_op_t  alu_opcode;
    logic     offset_strobe;
    logic     instr_execute;

    // Execute back to fetch
    logic  jump;
    addr_t jump_target;

    saturn_phase_gen phase_gen_i (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_clk_en   (i_clk_en),
        .i_bus_busy (i_bus_busy),
        .o_phases   (phases)
    );

    saturn_fetch #(
        .RESET_PC (RESET_PC)
    ) fetch_i (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_clk_en      (i_clk_en),
        .i_bus_busy    (i_bus_busy),
        .i_phases      (phases),
        .i_jump        (jump),
        .i_jump_target (jump_target),
        .o_pc          (o_pc)
    );

    // Second ALU source is not used by P= n
    saturn_inst_decoder decoder_i (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_clk_en        (i_clk_en),
        .i_bus_busy      (i_bus_busy),
        .i_phases        (phases),
        .i_nibble        (i_nibble),
        .i_current_pc    (o_pc),
        .o_instr_pc      (instr_pc),
        .o_alu_reg_dest  (alu_reg_dest),
        .o_alu_reg_src_1 (alu_reg_src_1),
        .o_alu_reg_src_2 (),
        .o_alu_imm_value (alu_imm_value),
        .o_alu_opcode    (alu_opcode),
        .o_instr_type    (o_instr_type),
        .o_offset_strobe (offset_strobe),
        .o_instr_decoded (o_instr_decoded),
        .o_instr_execute (instr_execute),
        .o_dbg_inst_addr (o_dbg_inst_addr)
    );

    saturn_exec exec_i (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_clk_en        (i_clk_en),
        .i_bus_busy      (i_bus_busy),
        .i_phases        (phases),
        .i_nibble        (i_nibble),
        .i_instr_pc      (instr_pc),
        .i_alu_reg_dest  (alu_reg_dest),
        .i_alu_reg_src_1 (alu_reg_src_1),
        .i_alu_imm_value (alu_imm_value),
        .i_alu_opcode    (alu_opcode),
        .i_instr_type    (o_instr_type),
        .i_offset_strobe (offset_strobe),
        .i_instr_decoded (o_instr_decoded),
        .i_instr_execute (instr_execute),
        .o_reg_p         (o_reg_p),
        .o_jump          (jump),
        .o_jump_target   (jump_target)
    );

endmodule

`default_nettype wire

// ==== verif/tb_saturn_core.sv ====
// Testbench for the Saturn front end
// Models the nibble memory, runs directed programs through the core
// and checks PC, register P and the decoded instruction stream

`default_nettype none

module tb_saturn_core import saturn_pkg::*; ();

    localparam int MEM_SIZE      = 4096;
    localparam int RESET_CYCLES  = 8;
    localparam int P_LOADS       = 5;
    localparam int STALL_INSTRS  = 5;
    // Nibbles executed by each directed program
    localparam int NOP_NIBBLES   = 14;
    localparam int P_NIBBLES     = 2 * P_LOADS;
    localparam int GOTO_NIBBLES  = 13;
    localparam int STALL_NIBBLES = 2 * 10;
    localparam int SUM_NIBBLES   = NOP_NIBBLES + P_NIBBLES + GOTO_NIBBLES + STALL_NIBBLES;
    // Factor 4 covers stalls, margin covers resets and settling
    localparam int TIMEOUT_CYCLES = 4 * SUM_NIBBLES * PHASE_COUNT + 200;

    logic        i_clk;
    logic        i_reset;
    logic        i_clk_en;
    logic        i_bus_busy;
    nibble_t     i_nibble;
    addr_t       o_pc;
    nibble_t     o_reg_p;
    instr_type_t o_instr_type;
    logic        o_instr_decoded;
    addr_t       o_dbg_inst_addr;

    nibble_t mem [0:MEM_SIZE-1];

    int     error_count    = 0;
    int     check_count    = 0;
    int     cycle_cnt      = 0;
    int     last_dec_cycle = 0;
    integer seed           = 32'hcb3a0440;
    logic   stall_en       = 1'b0;
    logic   dec_prev       = 1'b0;
    logic   dec_rise       = 1'b0;
    logic   busy_prev      = 1'b0;
    logic   reset_prev     = 1'b1;
    addr_t  pc_prev        = '0;
    addr_t  seq_plain   [0:STALL_INSTRS-1];
    addr_t  seq_stalled [0:STALL_INSTRS-1];

    // Memory answers the current address combinationally
    assign i_nibble = (o_pc < MEM_SIZE) ? mem[o_pc[11:0]] : 4'h0;

    saturn_core #(
        .RESET_PC (20'h0)
    ) dut_i (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_clk_en        (i_clk_en),
        .i_bus_busy      (i_bus_busy),
        .i_nibble        (i_nibble),
        .o_pc            (o_pc),
        .o_reg_p         (o_reg_p),
        .o_instr_type    (o_instr_type),
        .o_instr_decoded (o_instr_decoded),
        .o_dbg_inst_addr (o_dbg_inst_addr)
    );

    always #10 i_clk = ~i_clk;

    // Watchdog
    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", cycle_cnt);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // PC must hold across any edge that saw a busy bus
    always @(negedge i_clk) begin
        if (!reset_prev && busy_prev) begin
            check_count++;
            assert (o_pc === pc_prev) else begin
                $display("[FAIL] o_pc: moved from %h to %h while busy", pc_prev, o_pc);
                error_count++;
            end
        end
        busy_prev  = i_bus_busy;
        reset_prev = i_reset;
        pc_prev    = o_pc;
    end

    task automatic expect_eq(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            error_count++;
        end
    endtask

    // Offset counts from the nibble after the 6, sign-extended to 20 bits
    function automatic addr_t goto_target(input addr_t instr_addr, input offset_t offset);
        addr_t ext;
        ext = {{8{offset[11]}}, offset};
        return instr_addr + 20'd1 + ext;
    endfunction

    // Nibble 0 is a NOP
    task automatic clear_memory();
        for (int a = 0; a < MEM_SIZE; a++) begin
            mem[a] = 4'h0;
        end
    endtask

    task automatic put_p_load(input addr_t addr, input nibble_t n);
        mem[addr]     = 4'h2;
        mem[addr + 1] = n;
    endtask

    // Low offset nibble sits right after the 6
    task automatic write_goto(input addr_t addr, input offset_t offset);
        mem[addr]     = 4'h6;
        mem[addr + 1] = offset[3:0];
        mem[addr + 2] = offset[7:4];
        mem[addr + 3] = offset[11:8];
    endtask

    task automatic apply_reset();
        @(posedge i_clk);
        i_reset    <= 1'b1;
        i_clk_en   <= 1'b1;
        i_bus_busy <= 1'b0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        i_reset <= 1'b0;
        @(negedge i_clk);
        dec_prev       = o_instr_decoded;
        dec_rise       = 1'b0;
        last_dec_cycle = cycle_cnt;
    endtask

    // One clock, stall inputs driven at the edge, outputs sampled mid cycle
    task automatic step_cycle();
        logic [31:0] rnd;
        @(posedge i_clk);
        if (stall_en) begin
            rnd = $random(seed);
            i_bus_busy <= (rnd[1:0] == 2'd0);
            i_clk_en   <= (rnd[3:2] != 2'd0);
        end else begin
            i_bus_busy <= 1'b0;
            i_clk_en   <= 1'b1;
        end
        @(negedge i_clk);
        dec_rise = o_instr_decoded && !dec_prev;
        dec_prev = o_instr_decoded;
    endtask

    task automatic wait_decoded();
        step_cycle();
        while (!dec_rise) begin
            step_cycle();
        end
        last_dec_cycle = cycle_cnt;
    endtask

    // Latency 0 skips the spacing check
    task automatic await_instr(input addr_t addr, input instr_type_t kind, input int latency);
        int start;
        start = last_dec_cycle;
        wait_decoded();
        expect_eq("o_dbg_inst_addr", o_dbg_inst_addr, addr);
        expect_eq("o_instr_type", o_instr_type, kind);
        if (latency > 0) begin
            expect_eq("decoded spacing", cycle_cnt - start, latency);
        end
    endtask

    task automatic verify_reset_state();
        clear_memory();
        apply_reset();
        expect_eq("o_pc", o_pc, 20'h0);
        expect_eq("o_reg_p", o_reg_p, 4'h0);
        expect_eq("o_instr_type", o_instr_type, TYPE_NONE);
        expect_eq("o_instr_decoded", o_instr_decoded, 1'b0);
    endtask

    // Every nibble value except 2 and 6, in order
    task automatic run_nop_stream();
        int n;
        clear_memory();
        n = 0;
        for (int v = 0; v < 16; v++) begin
            if (v != 2 && v != 6) begin
                mem[n] = nibble_t'(v);
                n++;
            end
        end
        apply_reset();
        for (int i = 0; i < NOP_NIBBLES; i++) begin
            await_instr(addr_t'(i), TYPE_NOP, (i == 0) ? 0 : PHASE_COUNT);
            expect_eq("o_pc", o_pc, i);
        end
        step_cycle();
        expect_eq("o_pc", o_pc, NOP_NIBBLES);
    endtask

    // Immediates 5, 0, b, 6, 1
    task automatic load_p_values();
        nibble_t n;
        clear_memory();
        for (int k = 0; k < P_LOADS; k++) begin
            put_p_load(addr_t'(2 * k), nibble_t'(5 + 11 * k));
        end
        apply_reset();
        for (int k = 0; k < P_LOADS; k++) begin
            n = nibble_t'(5 + 11 * k);
            await_instr(addr_t'(2 * k), TYPE_ALU, (k == 0) ? 0 : 2 * PHASE_COUNT);
            expect_eq("o_pc", o_pc, 2 * k + 1);
            step_cycle();
            expect_eq("o_reg_p", o_reg_p, n);
            expect_eq("o_pc", o_pc, 2 * k + 2);
        end
    endtask

    task automatic jump_both_ways();
        offset_t fwd;
        offset_t back;
        addr_t   tgt_1;
        addr_t   back_at;
        addr_t   tgt_2;
        fwd     = 12'h100;
        // -240
        back    = 12'hf10;
        tgt_1   = goto_target(20'h0, fwd);
        back_at = tgt_1 + 20'd2;
        tgt_2   = goto_target(back_at, back);
        clear_memory();
        write_goto(20'h0, fwd);
        put_p_load(tgt_1, 4'h7);
        write_goto(back_at, back);
        put_p_load(tgt_2, 4'hc);
        apply_reset();
        // Forward, PC loads at the end of the last offset nibble
        await_instr(20'h0, TYPE_JUMP, 0);
        expect_eq("o_pc", o_pc, 20'h3);
        step_cycle();
        expect_eq("o_pc", o_pc, tgt_1);
        await_instr(tgt_1, TYPE_ALU, 2 * PHASE_COUNT);
        step_cycle();
        expect_eq("o_reg_p", o_reg_p, 4'h7);
        // Backward
        await_instr(back_at, TYPE_JUMP, 4 * PHASE_COUNT);
        step_cycle();
        expect_eq("o_pc", o_pc, tgt_2);
        await_instr(tgt_2, TYPE_ALU, 2 * PHASE_COUNT);
        step_cycle();
        expect_eq("o_reg_p", o_reg_p, 4'hc);
        // Runs on into the NOP fill
        await_instr(tgt_2 + 20'd2, TYPE_NOP, PHASE_COUNT);
    endtask

    // Same program clean and under random stalls
    task automatic replay_with_stalls();
        addr_t   tgt;
        nibble_t p_plain;
        nibble_t p_stalled;
        tgt = goto_target(20'h3, 12'h004);
        clear_memory();
        put_p_load(20'h0, 4'h3);
        mem[2] = 4'hb;
        write_goto(20'h3, 12'h004);
        // Skipped by the jump, would turn the target into P= 2
        mem[7] = 4'h2;
        put_p_load(tgt, 4'h9);
        mem[tgt + 2] = 4'ha;
        apply_reset();
        for (int k = 0; k < STALL_INSTRS; k++) begin
            wait_decoded();
            seq_plain[k] = o_dbg_inst_addr;
        end
        p_plain = o_reg_p;
        apply_reset();
        stall_en = 1'b1;
        for (int k = 0; k < STALL_INSTRS; k++) begin
            wait_decoded();
            seq_stalled[k] = o_dbg_inst_addr;
        end
        p_stalled = o_reg_p;
        stall_en  = 1'b0;
        expect_eq("o_reg_p", p_plain, 4'h9);
        expect_eq("o_reg_p", p_stalled, p_plain);
        expect_eq("o_dbg_inst_addr", seq_plain[0], 20'h0);
        expect_eq("o_dbg_inst_addr", seq_plain[1], 20'h2);
        expect_eq("o_dbg_inst_addr", seq_plain[2], 20'h3);
        expect_eq("o_dbg_inst_addr", seq_plain[3], tgt);
        expect_eq("o_dbg_inst_addr", seq_plain[4], tgt + 20'd2);
        for (int k = 0; k < STALL_INSTRS; k++) begin
            expect_eq("o_dbg_inst_addr", seq_stalled[k], seq_plain[k]);
        end
    endtask

    initial begin
        i_clk      = 1'b0;
        i_reset    = 1'b1;
        i_clk_en   = 1'b0;
        i_bus_busy = 1'b0;
        clear_memory();
        verify_reset_state();
        run_nop_stream();
        load_p_values();
        jump_both_ways();
        replay_with_stalls();
        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
src/saturn_pkg.sv
src/saturn_phase_gen.sv
src/saturn_fetch.sv
src/saturn_inst_decoder.sv
src/saturn_exec.sv
src/saturn_core.sv
verif/tb_saturn_core.sv

// ==== Bender.yml ====
package:
  name: saturn_core

sources:
  - src/saturn_pkg.sv
  - src/saturn_phase_gen.sv
  - src/saturn_fetch.sv
  - src/saturn_inst_decoder.sv
  - src/saturn_exec.sv
  - src/saturn_core.sv
  - target: test
    files:
      - verif/tb_saturn_core.sv
